/* bench/tb_gcn_combine.sv */
`timescale 1ns/1ps

module tb_gcn_combine;

  localparam int max_cycles = 4000;
  localparam logic signed [gcn_dims_pkg::data_width-1:0] min_val = 8'h80;
  localparam logic signed [gcn_dims_pkg::data_width-1:0] max_val = 8'h7f;

  logic                                    clk;
  logic                                    rst_n;
  logic                                    wr_en;
  logic [gcn_dims_pkg::src_addr_width-1:0] wr_addr;
  logic [gcn_dims_pkg::data_width-1:0]     wr_data;
  logic                                    start;
  logic                                    load_done;
  logic                                    feat_valid;
  logic [gcn_dims_pkg::data_width-1:0]     feat_data;
  logic                                    res_valid;
  logic [gcn_dims_pkg::col_width-1:0]      res_col;
  logic [gcn_dims_pkg::acc_width-1:0]      res_data;
  logic [gcn_ctrl_pkg::state_width-1:0]    phase;

  // model of the weight matrix (row-major) and the row being fed
  logic signed [gcn_dims_pkg::data_width-1:0] weights [gcn_dims_pkg::w_words];
  logic signed [gcn_dims_pkg::data_width-1:0] feat_row [gcn_dims_pkg::w_rows];

  logic [gcn_dims_pkg::col_width-1:0] exp_col;
  logic [gcn_dims_pkg::acc_width-1:0] exp_data;
  int cycles;
  int res_count;
  int res_errors;
  int stim_errors;

  gcn_combine_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .start      (start),
    .load_done  (load_done),
    .feat_valid (feat_valid),
    .feat_data  (feat_data),
    .res_valid  (res_valid),
    .res_col    (res_col),
    .res_data   (res_data),
    .phase      (phase)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // signed dot product of a feature row with one weight column
  function automatic logic [gcn_dims_pkg::acc_width-1:0] ref_dot(
    input logic signed [gcn_dims_pkg::data_width-1:0] w [gcn_dims_pkg::w_words],
    input logic signed [gcn_dims_pkg::data_width-1:0] f [gcn_dims_pkg::w_rows],
    input int col
  );
    int sum;
    sum = 0;
    for (int r = 0; r < gcn_dims_pkg::w_rows; r++) begin
      sum += int'(f[r]) * int'(w[r * gcn_dims_pkg::w_cols + col]);
    end
    return gcn_dims_pkg::acc_width'(sum);
  endfunction

  // result checker, outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      exp_col = '0;
    end else if (res_valid) begin
      exp_data = ref_dot(weights, feat_row, int'(exp_col));
      if (res_col !== exp_col) begin
        res_errors++;
        $display("Fail %0t res_col expected %0d actual %0d", $time, exp_col, res_col);
      end
      if (res_data !== exp_data) begin
        res_errors++;
        $display("Fail %0t res_data[%0d] expected %0d actual %0d", $time, exp_col,
                 $signed(exp_data), $signed(res_data));
      end
      if (exp_col == gcn_dims_pkg::col_width'(gcn_dims_pkg::w_cols - 1)) begin
        exp_col = '0;
      end else begin
        exp_col = exp_col + 1'b1;
      end
      res_count++;
    end
  end

  // limit well above the whole sequence of tests
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic write_weights();
    for (int k = 0; k < gcn_dims_pkg::w_words; k++) begin
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_addr <= gcn_dims_pkg::src_addr_width'(k);
      wr_data <= weights[k];
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // pulse start, optionally strobe features during the load, time load_done
  task automatic start_load(input bit strobe_load);
    int n;
    int base;
    base = res_count;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start      <= 1'b0;
    feat_valid <= strobe_load;
    feat_data  <= gcn_dims_pkg::data_width'($urandom);
    n = 1;
    @(negedge clk);
    while (!load_done && n < 100) begin
      @(posedge clk);
      // strobes stop long before the load ends
      feat_valid <= strobe_load && (n < 20);
      feat_data  <= gcn_dims_pkg::data_width'($urandom);
      n++;
      @(negedge clk);
    end
    if (!load_done) begin
      stim_errors++;
      $display("load_done never rose after start at %0t", $time);
    end else if (n != gcn_dims_pkg::w_words + 2) begin
      stim_errors++;
      $display("Fail %0t load_done latency expected %0d actual %0d", $time,
               gcn_dims_pkg::w_words + 2, n);
    end
    if (phase !== gcn_ctrl_pkg::st_feed) begin
      stim_errors++;
      $display("Fail %0t phase expected %0d actual %0d", $time, gcn_ctrl_pkg::st_feed, phase);
    end
    if (res_count != base) begin
      stim_errors++;
      $display("results appeared for strobes given during the load at %0t", $time);
    end
  endtask

  // strobes outside feed must not produce results
  task automatic ignored_strobes(input int cnt);
    int base;
    base = res_count;
    repeat (cnt) begin
      @(posedge clk);
      feat_valid <= 1'b1;
      feat_data  <= gcn_dims_pkg::data_width'($urandom);
    end
    @(posedge clk);
    feat_valid <= 1'b0;
    repeat (8) @(posedge clk);
    if (res_count != base) begin
      stim_errors++;
      $display("results appeared for strobes given outside feed at %0t", $time);
    end
  endtask

  task automatic feed_row(input int max_gap);
    int gap;
    int n;
    int target;
    target = res_count + gcn_dims_pkg::w_cols;
    for (int r = 0; r < gcn_dims_pkg::w_rows; r++) begin
      gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
      repeat (gap) begin
        @(posedge clk);
        feat_valid <= 1'b0;
      end
      @(posedge clk);
      feat_valid <= 1'b1;
      feat_data  <= feat_row[r];
    end
    @(posedge clk);
    feat_valid <= 1'b0;
    n = 1;
    @(negedge clk);
    while (!res_valid && n < 20) begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end
    if (n != 2) begin
      stim_errors++;
      $display("Fail %0t res_valid latency expected 2 actual %0d", $time, n);
    end
    n = 0;
    while (res_count < target && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (res_count != target) begin
      stim_errors++;
      $display("expected %0d results but got %0d at %0t", gcn_dims_pkg::w_cols,
               res_count + gcn_dims_pkg::w_cols - target, $time);
    end
  endtask

  initial begin
    void'($urandom(75));
    rst_n      <= 1'b0;
    start      <= 1'b0;
    wr_en      <= 1'b0;
    wr_addr    <= '0;
    wr_data    <= '0;
    feat_valid <= 1'b0;
    feat_data  <= '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    ignored_strobes(4);

    // random weights, load timing, then rows without and with gaps
    foreach (weights[k]) weights[k] = gcn_dims_pkg::data_width'($urandom);
    write_weights();
    start_load(1'b0);
    foreach (feat_row[r]) feat_row[r] = gcn_dims_pkg::data_width'($urandom);
    feed_row(0);
    repeat (3) begin
      foreach (feat_row[r]) feat_row[r] = gcn_dims_pkg::data_width'($urandom);
      feed_row(3);
    end

    // back to idle, extreme weights replace the random ones
    apply_reset();
    ignored_strobes(3);
    for (int k = 0; k < gcn_dims_pkg::w_words; k++) begin
      if (k % gcn_dims_pkg::w_cols == 0) begin
        weights[k] = min_val;
      end else if (k % gcn_dims_pkg::w_cols == 1) begin
        weights[k] = max_val;
      end else begin
        weights[k] = $urandom % 2 ? max_val : min_val;
      end
    end
    write_weights();
    start_load(1'b1);
    foreach (feat_row[r]) feat_row[r] = min_val;
    feed_row(0);
    foreach (feat_row[r]) feat_row[r] = $urandom % 2 ? max_val : min_val;
    feed_row(2);

    // restart from feed, banks reload from the unchanged source memory
    start_load(1'b0);
    foreach (feat_row[r]) feat_row[r] = gcn_dims_pkg::data_width'($urandom);
    feed_row(1);

    repeat (4) @(posedge clk);
    $display("results %0d, result errors %0d, other errors %0d", res_count, res_errors,
             stim_errors);
    if (res_errors == 0 && stim_errors == 0 && res_count > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* hw/gcn_combine_top.sv */
`timescale 1ns/1ps

module gcn_combine_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    wr_en,
  input  logic [gcn_dims_pkg::src_addr_width-1:0] wr_addr,
  input  logic [gcn_dims_pkg::data_width-1:0]     wr_data,
  input  logic                                    start,
  output logic                                    load_done,
  input  logic                                    feat_valid,
  input  logic [gcn_dims_pkg::data_width-1:0]     feat_data,
  output logic                                    res_valid,
  output logic [gcn_dims_pkg::col_width-1:0]      res_col,
  output logic [gcn_dims_pkg::acc_width-1:0]      res_data,
  output logic [gcn_ctrl_pkg::state_width-1:0]    phase
);

  // source memory to loader
  logic                                    src_rd_en;
  logic [gcn_dims_pkg::src_addr_width-1:0] src_rd_addr;
  logic [gcn_dims_pkg::data_width-1:0]     src_rd_data;

  // loader to banks
  logic [gcn_dims_pkg::w_cols-1:0]         bank_we;
  logic [gcn_dims_pkg::row_width-1:0]      bank_wr_row;
  logic [gcn_dims_pkg::data_width-1:0]     bank_wr_data;
  logic                                    load_last;
  logic                                    load_run;

  // compute path
  logic                                    feat_en;
  logic                                    acc_clr;
  logic [gcn_dims_pkg::row_width-1:0]      rd_row;
  logic [gcn_dims_pkg::data_width-1:0]     bank_rd [gcn_dims_pkg::w_cols];
  logic [gcn_dims_pkg::acc_width-1:0]      lane_acc [gcn_dims_pkg::w_cols];

  weight_src_ram u_src_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (src_rd_en),
    .rd_addr (src_rd_addr),
    .rd_data (src_rd_data)
  );

  weight_loader u_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_run     (load_run),
    .src_rd_en    (src_rd_en),
    .src_rd_addr  (src_rd_addr),
    .src_rd_data  (src_rd_data),
    .bank_we      (bank_we),
    .bank_wr_row  (bank_wr_row),
    .bank_wr_data (bank_wr_data),
    .load_last    (load_last)
  );

  // one bank and one lane per output column
  for (genvar i = 0; i < gcn_dims_pkg::w_cols; i++) begin : g_col
    weight_bank u_bank (
      .clk     (clk),
      .we      (bank_we[i]),
      .wr_row  (bank_wr_row),
      .wr_data (bank_wr_data),
      .rd_row  (rd_row),
      .rd_data (bank_rd[i])
    );

    mac_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .feat_en   (feat_en),
      .feat_data (feat_data),
      .acc_clr   (acc_clr),
      .weight    (bank_rd[i]),
      .acc       (lane_acc[i])
    );
  end

  gcn_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .load_last  (load_last),
    .feat_valid (feat_valid),
    .load_run   (load_run),
    .load_done  (load_done),
    .feat_en    (feat_en),
    .acc_clr    (acc_clr),
    .rd_row     (rd_row),
    .emit_col   (res_col),
    .res_valid  (res_valid),
    .state      (phase)
  );

  // result column picked by the emit counter
  assign res_data = lane_acc[res_col];

endmodule

/* hw/gcn_ctrl.sv */
`timescale 1ns/1ps

module gcn_ctrl (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   start,
  input  logic                                   load_last,
  input  logic                                   feat_valid,
  output logic                                   load_run,
  output logic                                   load_done,
  output logic                                   feat_en,
  output logic                                   acc_clr,
  output logic [gcn_dims_pkg::row_width-1:0]     rd_row,
  output logic [gcn_dims_pkg::col_width-1:0]     emit_col,
  output logic                                   res_valid,
  output logic [gcn_ctrl_pkg::state_width-1:0]   state
);

  logic [gcn_dims_pkg::row_width-1:0] row_cnt;
  logic                               row_last;
  logic                               col_last;

  assign row_last = (row_cnt == gcn_dims_pkg::row_width'(gcn_dims_pkg::w_rows - 1));
  assign col_last = (emit_col == gcn_dims_pkg::col_width'(gcn_dims_pkg::w_cols - 1));

  // features count only in feed, a restart takes priority
  assign feat_en = feat_valid && !start && (state == gcn_ctrl_pkg::st_feed);
  assign acc_clr = feat_en && (row_cnt == '0);
  assign rd_row  = row_cnt;

  assign load_run  = (state == gcn_ctrl_pkg::st_load);
  assign res_valid = (state == gcn_ctrl_pkg::st_emit);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= gcn_ctrl_pkg::st_idle;
      row_cnt   <= '0;
      emit_col  <= '0;
      load_done <= 1'b0;
    end else begin
      case (state)
        gcn_ctrl_pkg::st_idle: begin
          if (start) begin
            state <= gcn_ctrl_pkg::st_load;
          end
        end
        gcn_ctrl_pkg::st_load: begin
          if (load_last) begin
            state     <= gcn_ctrl_pkg::st_feed;
            load_done <= 1'b1;
          end
        end
        gcn_ctrl_pkg::st_feed: begin
          if (start) begin
            // reload with new weights, partial row is dropped
            state     <= gcn_ctrl_pkg::st_load;
            load_done <= 1'b0;
            row_cnt   <= '0;
          end else if (feat_en) begin
            if (row_last) begin
              row_cnt <= '0;
              state   <= gcn_ctrl_pkg::st_drain;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end
        end
        gcn_ctrl_pkg::st_drain: begin
          emit_col <= '0;
          state    <= gcn_ctrl_pkg::st_emit;
        end
        gcn_ctrl_pkg::st_emit: begin
          if (col_last) begin
            emit_col <= '0;
            state    <= gcn_ctrl_pkg::st_feed;
          end else begin
            emit_col <= emit_col + 1'b1;
          end
        end
        default: begin
          state <= gcn_ctrl_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

/* hw/gcn_ctrl_pkg.sv */
package gcn_ctrl_pkg;

  // width of the state code, also exported as the phase output
  localparam int state_width = 3;

  // controller states
  // waiting for weights and a start pulse
  localparam logic [state_width-1:0] st_idle = 3'd0;
  // copying the source memory into the column banks
  localparam logic [state_width-1:0] st_load = 3'd1;
  // accepting feature elements
  localparam logic [state_width-1:0] st_feed = 3'd2;
  // one cycle for the last product to reach the accumulators
  localparam logic [state_width-1:0] st_drain = 3'd3;
  // one result column per cycle
  localparam logic [state_width-1:0] st_emit = 3'd4;

endpackage

/* hw/gcn_dims_pkg.sv */
package gcn_dims_pkg;

  // element width of a signed weight or feature
  localparam int data_width = 8;

  // weight matrix shape, rows also set the feature row length
  localparam int w_rows = 8;
  localparam int w_cols = 4;

  // linear source memory holds the whole matrix, row-major
  localparam int w_words = w_rows * w_cols;

  // address and index widths
  localparam int src_addr_width = 5;
  localparam int row_width = 3;
  localparam int col_width = 2;

  // accumulator width
  // 16-bit products summed over 8 rows need 19 bits, one spare
  localparam int acc_width = 20;

endpackage

/* hw/mac_lane.sv */
`timescale 1ns/1ps

module mac_lane (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      feat_en,
  input  logic        [gcn_dims_pkg::data_width-1:0] feat_data,
  input  logic                                      acc_clr,
  input  logic        [gcn_dims_pkg::data_width-1:0] weight,
  output logic signed [gcn_dims_pkg::acc_width-1:0]  acc
);

  logic                                           feat_en_d;
  logic                                           acc_clr_d;
  logic        [gcn_dims_pkg::data_width-1:0]     feat_data_d;
  logic signed [2*gcn_dims_pkg::data_width-1:0]   prod;
  logic signed [gcn_dims_pkg::acc_width-1:0]      prod_ext;

  // delay intake by one cycle so it meets the registered bank read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      feat_en_d <= 1'b0;
      acc_clr_d <= 1'b0;
    end else begin
      feat_en_d <= feat_en;
      acc_clr_d <= feat_en && acc_clr;
    end
  end

  always_ff @(posedge clk) begin
    feat_data_d <= feat_data;
  end

  // both operands signed, product sign extended to accumulator width
  assign prod     = $signed(feat_data_d) * $signed(weight);
  assign prod_ext = prod;

  // first product of a row replaces the old sum
  // value then holds until the next clear
  always_ff @(posedge clk) begin
    if (feat_en_d) begin
      if (acc_clr_d) begin
        acc <= prod_ext;
      end else begin
        acc <= acc + prod_ext;
      end
    end
  end

endmodule

/* hw/weight_bank.sv */
`timescale 1ns/1ps

module weight_bank (
  input  logic                               clk,
  input  logic                               we,
  input  logic [gcn_dims_pkg::row_width-1:0]  wr_row,
  input  logic [gcn_dims_pkg::data_width-1:0] wr_data,
  input  logic [gcn_dims_pkg::row_width-1:0]  rd_row,
  output logic [gcn_dims_pkg::data_width-1:0] rd_data
);

  // one weight column, indexed by row
  logic [gcn_dims_pkg::data_width-1:0] mem [gcn_dims_pkg::w_rows];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end
  end

  // read every cycle, data one cycle behind rd_row
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_row];
  end

endmodule

/* hw/weight_loader.sv */
`timescale 1ns/1ps

module weight_loader (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    load_run,
  output logic                                    src_rd_en,
  output logic [gcn_dims_pkg::src_addr_width-1:0] src_rd_addr,
  input  logic [gcn_dims_pkg::data_width-1:0]     src_rd_data,
  output logic [gcn_dims_pkg::w_cols-1:0]         bank_we,
  output logic [gcn_dims_pkg::row_width-1:0]      bank_wr_row,
  output logic [gcn_dims_pkg::data_width-1:0]     bank_wr_data,
  output logic                                    load_last
);

  logic [gcn_dims_pkg::src_addr_width-1:0] addr_cnt;
  logic                                    all_issued;
  logic                                    rd_valid;
  logic [gcn_dims_pkg::col_width-1:0]      col_idx;
  logic [gcn_dims_pkg::row_width-1:0]      row_idx;
  logic                                    last_col;
  logic                                    last_row;

  // one read per cycle until every word has been requested
  assign src_rd_en   = load_run && !all_issued;
  assign src_rd_addr = addr_cnt;

  assign last_col = (col_idx == gcn_dims_pkg::col_width'(gcn_dims_pkg::w_cols - 1));
  assign last_row = (row_idx == gcn_dims_pkg::row_width'(gcn_dims_pkg::w_rows - 1));

  // read side, counters restart whenever load_run drops
  always_ff @(posedge clk) begin
    if (!rst_n || !load_run) begin
      addr_cnt   <= '0;
      all_issued <= 1'b0;
      rd_valid   <= 1'b0;
    end else begin
      rd_valid <= src_rd_en;
      if (src_rd_en) begin
        if (addr_cnt == gcn_dims_pkg::src_addr_width'(gcn_dims_pkg::w_words - 1)) begin
          all_issued <= 1'b1;
        end else begin
          addr_cnt <= addr_cnt + 1'b1;
        end
      end
    end
  end

  // write side follows returned data only
  // column wraps into the row, word k goes to bank k mod cols
  always_ff @(posedge clk) begin
    if (!rst_n || !load_run) begin
      col_idx <= '0;
      row_idx <= '0;
    end else if (rd_valid) begin
      if (last_col) begin
        col_idx <= '0;
        row_idx <= row_idx + 1'b1;
      end else begin
        col_idx <= col_idx + 1'b1;
      end
    end
  end

  // one-hot bank select from the column index
  always_comb begin
    for (int i = 0; i < gcn_dims_pkg::w_cols; i++) begin
      bank_we[i] = rd_valid && (col_idx == gcn_dims_pkg::col_width'(i));
    end
  end

  assign bank_wr_row  = row_idx;
  assign bank_wr_data = src_rd_data;

  // final word of the matrix is being written this cycle
  assign load_last = rd_valid && last_row && last_col;

endmodule

/* hw/weight_src_ram.sv */
`timescale 1ns/1ps

module weight_src_ram (
  input  logic                                   clk,
  input  logic                                   wr_en,
  input  logic [gcn_dims_pkg::src_addr_width-1:0] wr_addr,
  input  logic [gcn_dims_pkg::data_width-1:0]     wr_data,
  input  logic                                   rd_en,
  input  logic [gcn_dims_pkg::src_addr_width-1:0] rd_addr,
  output logic [gcn_dims_pkg::data_width-1:0]     rd_data
);

  // whole weight matrix, row-major
  logic [gcn_dims_pkg::data_width-1:0] mem [gcn_dims_pkg::w_words];

  // external write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // loader read port, output holds when not enabled
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_gcn_combine -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verilog.f */
hw/gcn_dims_pkg.sv
hw/gcn_ctrl_pkg.sv
hw/weight_src_ram.sv
hw/weight_loader.sv
hw/weight_bank.sv
hw/mac_lane.sv
hw/gcn_ctrl.sv
hw/gcn_combine_top.sv
bench/tb_gcn_combine.sv
